/* bench/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen
#(
	parameter int PERIOD       = 40,
	parameter int RESET_CYCLES = 8
)
(
	output logic CLK,
	output logic RST
);

	initial
	begin
		CLK = 1'b0;
		forever #(PERIOD / 2) CLK = ~CLK;
	end

	// reset is released on a rising edge, so the DUT still sees it low there.
	initial
	begin
		RST = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		RST <= 1'b1;
	end

endmodule

/* bench/sdram_checker.sv */
`timescale 1ns/1ps

`include "sdram_settings.svh"

module sdram_checker
(
	input  logic                   CLK,
	input  logic                   RST,
	input  logic                   access,
	input  logic                   busy,
	input  sdram_pkg::sdram_pins_t pins,
	input  logic                   exp_valid,
	input  logic [127:0]           exp_name,
	input  sdram_pkg::row_addr_t   exp_row,
	input  sdram_pkg::col_addr_t   exp_col,
	input  logic                   exp_write,
	input  logic                   exp_hit,
	input  logic                   check_done,
	output int                     pin_errors,
	output int                     busy_errors,
	output int                     other_errors
);

	import sdram_pkg::*;

	typedef struct packed
	{
		logic [127:0] name;
		row_addr_t    row;
		col_addr_t    col;
		logic         write;
		logic         hit;
	} txn_t;

	txn_t        txn_q[$];
	int          due_q[$];
	sdram_pins_t want_q[$];
	txn_t        next_txn;
	logic [127:0] cur_name;
	logic        exp_busy;
	logic [3:0]  ctrl;
	int          cyc;
	int          busy_from;
	int          busy_until;
	int          last_edge;
	logic        have_last;
	sdram_cmd_t  last_cmd;
	int          cmds_expected;
	int          cmds_seen;
	logic        finished;

	initial
	begin
		pin_errors    = 0;
		busy_errors   = 0;
		other_errors  = 0;
		cyc           = 0;
		busy_from     = 0;
		busy_until    = 0;
		last_edge     = 0;
		have_last     = 1'b0;
		last_cmd      = NOP;
		cmds_expected = 0;
		cmds_seen     = 0;
		finished      = 1'b0;
		cur_name      = "reset";
	end

	// standard SDRAM truth table with chip select held low.
	function automatic sdram_pins_t pins_for(sdram_cmd_t cmd, row_addr_t r, col_addr_t c);
		sdram_pins_t p;
		p = '{cs_n: 1'b0, ras_n: 1'b1, cas_n: 1'b1, we_n: 1'b1, addr: '0};
		case (cmd)
			PRCH:
			begin
				p.ras_n    = 1'b0;
				p.we_n     = 1'b0;
				p.addr[10] = 1'b1;
			end
			ACTV:
			begin
				p.ras_n = 1'b0;
				p.addr  = r;
			end
			READ:
			begin
				p.cas_n = 1'b0;
				p.addr  = {{(`SDRAM_ROW_BITS - `SDRAM_COL_BITS){1'b0}}, c};
			end
			WRTE:
			begin
				p.cas_n = 1'b0;
				p.we_n  = 1'b0;
				p.addr  = {{(`SDRAM_ROW_BITS - `SDRAM_COL_BITS){1'b0}}, c};
			end
			default:
			begin
				p.addr = '0;
			end
		endcase
		return p;
	endfunction

	function automatic string pins_text(sdram_pins_t p);
		case ({p.cs_n, p.ras_n, p.cas_n, p.we_n})
			4'b0111: return "NOP";
			4'b0010: return "PRCH";
			4'b0011: return "ACTV";
			4'b0101: return "READ";
			4'b0100: return "WRTE";
			default: return "unknown";
		endcase
	endfunction

	// minimum distance in cycles between two commands on the bank.
	function automatic int gap_after(sdram_cmd_t prev, sdram_cmd_t next);
		if (prev == ACTV)
			return `SDRAM_WAIT_ACTV;
		else if (((prev == READ) || (prev == WRTE)) && (next == prev))
			return 1;
		else
			return `SDRAM_WAIT_OTHER;
	endfunction

	task automatic schedule_txn(input txn_t t, input int accept_edge);
		sdram_cmd_t rw;
		sdram_cmd_t first;
		int         due;
		rw    = t.write ? WRTE : READ;
		first = t.hit ? rw : PRCH;
		due   = accept_edge + 1;
		if (have_last && ((last_edge + gap_after(last_cmd, first)) > due))
			due = last_edge + gap_after(last_cmd, first);
		if (!t.hit)
		begin
			due_q.push_back(due);
			want_q.push_back(pins_for(PRCH, t.row, t.col));
			due = due + `SDRAM_WAIT_OTHER;
			due_q.push_back(due);
			want_q.push_back(pins_for(ACTV, t.row, t.col));
			due = due + `SDRAM_WAIT_ACTV;
		end
		due_q.push_back(due);
		want_q.push_back(pins_for(rw, t.row, t.col));
		cmds_expected = cmds_expected + (t.hit ? 1 : 3);
		busy_from     = accept_edge;
		busy_until    = due;
		last_cmd      = rw;
		last_edge     = due;
		have_last     = 1'b1;
		cur_name      = t.name;
	endtask

	// sampling on the falling edge sees everything the rising edge settled.
	// cyc then equals the index of the rising edge just passed.
	always @(negedge CLK)
	begin
		cyc  = cyc + 1;
		ctrl = {pins.cs_n, pins.ras_n, pins.cas_n, pins.we_n};
		if (exp_valid === 1'b1)
		begin
			next_txn = {exp_name, exp_row, exp_col, exp_write, exp_hit};
			txn_q.push_back(next_txn);
		end
		if (!RST)
		begin
			if (ctrl !== 4'b0111)
			begin
				$display("FAIL reset: pins expected NOP, actual %0s", pins_text(pins));
				pin_errors = pin_errors + 1;
			end
			if (busy !== 1'b0)
			begin
				$display("FAIL reset: busy expected 0, actual %b", busy);
				busy_errors = busy_errors + 1;
			end
		end
		else
		begin
			if ((due_q.size() > 0) && (due_q[0] == cyc))
			begin
				if (pins !== want_q[0])
				begin
					$display("FAIL %0s: pins expected %0s addr %h, actual %0s addr %h",
						cur_name, pins_text(want_q[0]), want_q[0].addr,
						pins_text(pins), pins.addr);
					pin_errors = pin_errors + 1;
				end
				due_q.delete(0);
				want_q.delete(0);
			end
			else if (ctrl !== 4'b0111)
			begin
				$display("FAIL %0s: pins at cycle %0d expected NOP, actual %0s addr %h",
					cur_name, cyc, pins_text(pins), pins.addr);
				pin_errors = pin_errors + 1;
			end
			if (ctrl !== 4'b0111)
				cmds_seen = cmds_seen + 1;
			exp_busy = (cyc >= busy_from) && (cyc < busy_until);
			if (busy !== exp_busy)
			begin
				$display("FAIL %0s: busy at cycle %0d expected %b, actual %b",
					cur_name, cyc, exp_busy, busy);
				busy_errors = busy_errors + 1;
			end
			// the strobe seen now is taken on the next rising edge.
			if ((access === 1'b1) && !exp_busy)
			begin
				if (txn_q.size() == 0)
				begin
					$display("strobe accepted at cycle %0d with no transaction pending", cyc);
					other_errors = other_errors + 1;
				end
				else
				begin
					next_txn = txn_q.pop_front();
					schedule_txn(next_txn, cyc + 1);
				end
			end
		end
		if ((check_done === 1'b1) && !finished)
		begin
			finished = 1'b1;
			if (cmds_seen != cmds_expected)
			begin
				$display("FAIL command_count: expected %0d, actual %0d",
					cmds_expected, cmds_seen);
				other_errors = other_errors + 1;
			end
			if ((txn_q.size() != 0) || (due_q.size() != 0))
			begin
				$display("%0d transactions and %0d commands never showed up on the pins",
					txn_q.size(), due_q.size());
				other_errors = other_errors + 1;
			end
		end
	end

endmodule

/* bench/sdram_ctl_tb.sv */
`timescale 1ns/1ps

module sdram_ctl_tb;

	import sdram_pkg::*;

	localparam int          CLK_PERIOD      = 40;
	localparam int          RESET_CYCLES    = 8;
	localparam int          NUM_TESTS       = 13;
	localparam int          WATCHDOG_CYCLES = NUM_TESTS * 20 + RESET_CYCLES;
	localparam logic [31:0] RAND_SEED       = 32'h0e223eb8;

	typedef struct packed
	{
		logic [127:0] name;
		row_addr_t    row;
		col_addr_t    col;
		logic         write;
		logic         hit;
		logic         stray;
		logic         rnd;
		logic         early;
	} entry_t;

	logic         CLK;
	logic         RST;
	logic         access;
	row_addr_t    row;
	col_addr_t    col;
	logic         write;
	logic         busy;
	sdram_pins_t  pins;
	logic         exp_valid;
	logic [127:0] exp_name;
	row_addr_t    exp_row;
	col_addr_t    exp_col;
	logic         exp_write;
	logic         exp_hit;
	logic         check_done;
	int           pin_errors;
	int           busy_errors;
	int           other_errors;
	entry_t       tests [NUM_TESTS];
	int           fill_count;
	int           i;
	logic [31:0]  rnd_word;

	clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) clk_i
	(
		.CLK (CLK),
		.RST (RST)
	);

	sdram_ctl dut_i
	(
		.CLK    (CLK),
		.RST    (RST),
		.access (access),
		.row    (row),
		.col    (col),
		.write  (write),
		.busy   (busy),
		.pins   (pins)
	);

	sdram_checker chk_i
	(
		.CLK          (CLK),
		.RST          (RST),
		.access       (access),
		.busy         (busy),
		.pins         (pins),
		.exp_valid    (exp_valid),
		.exp_name     (exp_name),
		.exp_row      (exp_row),
		.exp_col      (exp_col),
		.exp_write    (exp_write),
		.exp_hit      (exp_hit),
		.check_done   (check_done),
		.pin_errors   (pin_errors),
		.busy_errors  (busy_errors),
		.other_errors (other_errors)
	);

	task automatic add_test(input logic [127:0] name, input row_addr_t r, input col_addr_t c,
		input logic wr, input logic hit, input logic stray, input logic rnd, input logic early);
		entry_t e;
		e.name  = name;
		e.row   = r;
		e.col   = c;
		e.write = wr;
		e.hit   = hit;
		e.stray = stray;
		e.rnd   = rnd;
		e.early = early;
		if (rnd)
		begin
			rnd_word = $urandom();
			e.col    = rnd_word[$bits(col_addr_t)-1:0];
		end
		tests[fill_count] = e;
		fill_count        = fill_count + 1;
	endtask

	// name, row, col, write, page hit, stray strobe, random column, back-to-back.
	task automatic fill_tests();
		fill_count = 0;
		add_test("first_read",      12'h123, 8'h10, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
		add_test("same_row_read",   12'h123, 8'h11, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
		add_test("same_row_read2",  12'h123, 8'h12, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
		add_test("same_row_write",  12'h123, 8'h20, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
		add_test("same_row_write2", 12'h123, 8'h21, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1);
		add_test("new_row_write",   12'h7a5, 8'h33, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
		add_test("rand_col_read",   12'h7a5, 8'h00, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0);
		add_test("rand_col_write",  12'h7a5, 8'h00, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0);
		add_test("old_row_read",    12'h123, 8'h44, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
		add_test("a10_row_read",    12'h400, 8'h55, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
		add_test("rand_col_write2", 12'h400, 8'h00, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0);
		add_test("top_row_write",   12'hfff, 8'hff, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
		add_test("top_row_read",    12'hfff, 8'h00, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
	endtask

	task automatic wait_idle();
		@(negedge CLK);
		while (busy !== 1'b0)
			@(negedge CLK);
	endtask

	task automatic run_test(input entry_t e);
		// a back-to-back entry does not wait to see busy low first, so its strobe
		// meets the edge on which busy falls and is held until it is taken.
		if (!e.early)
			wait_idle();
		@(posedge CLK);
		access    <= 1'b1;
		row       <= e.row;
		col       <= e.col;
		write     <= e.write;
		exp_valid <= 1'b1;
		exp_name  <= e.name;
		exp_row   <= e.row;
		exp_col   <= e.col;
		exp_write <= e.write;
		exp_hit   <= e.hit;
		@(negedge CLK);
		while (busy !== 1'b0)
		begin
			@(posedge CLK);
			exp_valid <= 1'b0;
			@(negedge CLK);
		end
		@(posedge CLK);
		access    <= 1'b0;
		exp_valid <= 1'b0;
		if (e.stray)
		begin
			// a second strobe while the miss sequence runs must be dropped.
			@(posedge CLK);
			access <= 1'b1;
			@(posedge CLK);
			access <= 1'b0;
		end
	endtask

	initial
	begin
		access     = 1'b0;
		row        = '0;
		col        = '0;
		write      = 1'b0;
		exp_valid  = 1'b0;
		exp_name   = '0;
		exp_row    = '0;
		exp_col    = '0;
		exp_write  = 1'b0;
		exp_hit    = 1'b0;
		check_done = 1'b0;
		rnd_word   = $urandom(RAND_SEED);
		fill_tests();
		@(posedge RST);
		for (i = 0; i < NUM_TESTS; i++)
			run_test(tests[i]);
		wait_idle();
		repeat (4) @(posedge CLK);
		check_done <= 1'b1;
		repeat (2) @(posedge CLK);
		$display("errors: pins %0d, busy %0d, other %0d", pin_errors, busy_errors, other_errors);
		if ((pin_errors + busy_errors + other_errors) == 0)
		begin
			$display("TESTBENCH PASSED");
		end
		else
		begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog: run did not finish within %0d clock periods", WATCHDOG_CYCLES);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* include/sdram_settings.svh */
`ifndef SDRAM_SETTINGS_SVH
`define SDRAM_SETTINGS_SVH

// width of the page (row) address.
// It also sets the width of the SDRAM address pins.
`define SDRAM_ROW_BITS 12

// width of the column address inside an open page.
`define SDRAM_COL_BITS 8

// cycles from an activate to the next command of any kind.
`define SDRAM_WAIT_ACTV 2

// cycles after a precharge, read or write before a different command.
// A repeated read or write to the open page does not wait for this.
`define SDRAM_WAIT_OTHER 3

// the bank timer counts in two bits and expires at 3.
// Neither wait may be zero, and neither may exceed four cycles.

`endif

/* sdram_ctl.f */
+incdir+include
verilog/sdram_pkg.sv
verilog/bank_timer.sv
verilog/cmd_sequencer.sv
verilog/pin_encoder.sv
verilog/sdram_ctl.sv
bench/clock_gen.sv
bench/sdram_checker.sv
bench/sdram_ctl_tb.sv

/* verilog/bank_timer.sv */
`timescale 1ns/1ps

`include "sdram_settings.svh"

module bank_timer
(
	input  logic                  CLK,
	input  logic                  RST,
	input  sdram_pkg::sdram_cmd_t command,
	input  logic                  change_requested,
	output logic                  change_possible
);

	import sdram_pkg::*;

	// the counter counts up and stops at this value.
	localparam logic [1:0] CNT_EXPIRED = 2'h3;

	// load values chosen so that the counter reaches CNT_EXPIRED exactly
	// the given number of cycles after the command was taken.
	localparam logic [1:0] LOAD_ACTV  = 2'(4 - `SDRAM_WAIT_ACTV);
	localparam logic [1:0] LOAD_OTHER = 2'(4 - `SDRAM_WAIT_OTHER);

	sdram_cmd_t state;
	logic [1:0] counter;
	logic       state_is_rw;
	logic       repeat_rw;
	logic       take;

	assign state_is_rw = (state == READ) || (state == WRTE);

	// a read after a read (or a write after a write) to the open page
	// needs no spacing, so it may go at once.
	assign repeat_rw = state_is_rw && (command == state);

	assign change_possible = (counter == CNT_EXPIRED) || repeat_rw;

	// the sequencer steps in the same cycle, so both sides agree on this.
	assign take = change_requested && change_possible;

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			// after reset the bank is taken as precharged and settled.
			state   <= PRCH;
			counter <= CNT_EXPIRED;
		end
		else if (take)
		begin
			state <= command;
			if (command == ACTV)
			begin
				counter <= LOAD_ACTV;
			end
			else
			begin
				counter <= LOAD_OTHER;
			end
		end
		else if (counter != CNT_EXPIRED)
		begin
			counter <= counter + 2'h1;
		end
	end

endmodule

/* verilog/cmd_sequencer.sv */
`timescale 1ns/1ps

`include "sdram_settings.svh"

module cmd_sequencer
(
	input  logic                  CLK,
	input  logic                  RST,
	input  logic                  access,
	input  sdram_pkg::row_addr_t  row,
	input  sdram_pkg::col_addr_t  col,
	input  logic                  write,
	input  logic                  change_possible,
	output sdram_pkg::sdram_cmd_t command,
	output logic                  change_requested,
	output logic                  issue,
	output sdram_pkg::row_addr_t  issue_row,
	output sdram_pkg::col_addr_t  issue_col
);

	import sdram_pkg::*;

	// position in the three-entry sequence; STEP_IDLE means nothing is left.
	localparam logic [1:0] STEP_PRCH = 2'd0;
	localparam logic [1:0] STEP_ACTV = 2'd1;
	localparam logic [1:0] STEP_RW   = 2'd2;
	localparam logic [1:0] STEP_IDLE = 2'd3;

	logic [1:0] step;
	sdram_cmd_t rw_cmd;
	row_addr_t  req_row;
	col_addr_t  req_col;
	row_addr_t  open_page;
	logic       page_valid;
	logic       accept;
	logic       page_hit;
	logic       take;

	assign change_requested = (step != STEP_IDLE);

	// strobes are only seen while no sequence is running.
	assign accept = access && !change_requested;

	assign page_hit = page_valid && (row == open_page);

	assign take  = change_requested && change_possible;
	assign issue = take;

	assign issue_row = req_row;
	assign issue_col = req_col;

	always_comb
	begin
		case (step)
			STEP_PRCH: command = PRCH;
			STEP_ACTV: command = ACTV;
			STEP_RW:   command = rw_cmd;
			default:   command = NOP;
		endcase
	end

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			step       <= STEP_IDLE;
			page_valid <= 1'b0;
		end
		else if (accept)
		begin
			// a hit skips straight to the read or write.
			step <= page_hit ? STEP_RW : STEP_PRCH;
		end
		else if (take)
		begin
			step <= step + 2'd1;
			if (command == PRCH)
			begin
				page_valid <= 1'b0;
			end
			else if (command == ACTV)
			begin
				page_valid <= 1'b1;
			end
		end
	end

	// request fields are captured once so the encoder sees stable values.
	always_ff @(posedge CLK)
	begin
		if (accept)
		begin
			req_row <= row;
			req_col <= col;
			rw_cmd  <= write ? WRTE : READ;
		end
		if (take && (command == ACTV))
		begin
			open_page <= req_row;
		end
	end

endmodule

/* verilog/pin_encoder.sv */
`timescale 1ns/1ps

module pin_encoder
(
	input  logic                   CLK,
	input  logic                   RST,
	input  logic                   issue,
	input  sdram_pkg::sdram_cmd_t  command,
	input  sdram_pkg::row_addr_t   row,
	input  sdram_pkg::col_addr_t   col,
	output sdram_pkg::sdram_pins_t pins
);

	import sdram_pkg::*;

	// chip selected with all strobes high decodes as NOP on the SDRAM.
	localparam sdram_pins_t PINS_NOP = '{
		cs_n:  1'b0,
		ras_n: 1'b1,
		cas_n: 1'b1,
		we_n:  1'b1,
		addr:  '0
	};

	sdram_pins_t pins_next;

	always_comb
	begin
		pins_next = PINS_NOP;
		if (issue)
		begin
			case (command)
				PRCH:
				begin
					pins_next.ras_n = 1'b0;
					pins_next.we_n  = 1'b0;
					// A10 high closes every bank.
					pins_next.addr[10] = 1'b1;
				end
				ACTV:
				begin
					pins_next.ras_n = 1'b0;
					pins_next.addr  = row;
				end
				READ:
				begin
					pins_next.cas_n = 1'b0;
					pins_next.addr  = row_addr_t'(col);
				end
				WRTE:
				begin
					pins_next.cas_n = 1'b0;
					pins_next.we_n  = 1'b0;
					pins_next.addr  = row_addr_t'(col);
				end
				default:
				begin
					pins_next = PINS_NOP;
				end
			endcase
		end
	end

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			pins <= PINS_NOP;
		end
		else
		begin
			pins <= pins_next;
		end
	end

endmodule

/* verilog/sdram_ctl.sv */
`timescale 1ns/1ps

`include "sdram_settings.svh"

module sdram_ctl
(
	input  logic                   CLK,
	input  logic                   RST,
	input  logic                   access,
	input  sdram_pkg::row_addr_t   row,
	input  sdram_pkg::col_addr_t   col,
	input  logic                   write,
	output logic                   busy,
	output sdram_pkg::sdram_pins_t pins
);

	import sdram_pkg::*;

	sdram_cmd_t command;
	logic       change_requested;
	logic       change_possible;
	logic       issue;
	row_addr_t  issue_row;
	col_addr_t  issue_col;

	// the client waits as long as commands of the sequence remain.
	assign busy = change_requested;

	cmd_sequencer seq_i
	(
		.CLK              (CLK),
		.RST              (RST),
		.access           (access),
		.row              (row),
		.col              (col),
		.write            (write),
		.change_possible  (change_possible),
		.command          (command),
		.change_requested (change_requested),
		.issue            (issue),
		.issue_row        (issue_row),
		.issue_col        (issue_col)
	);

	bank_timer timer_i
	(
		.CLK              (CLK),
		.RST              (RST),
		.command          (command),
		.change_requested (change_requested),
		.change_possible  (change_possible)
	);

	pin_encoder enc_i
	(
		.CLK     (CLK),
		.RST     (RST),
		.issue   (issue),
		.command (command),
		.row     (issue_row),
		.col     (issue_col),
		.pins    (pins)
	);

endmodule

/* verilog/sdram_pkg.sv */
package sdram_pkg;

	`include "sdram_settings.svh"

	// commands as seen by the bank.
	// NOP is also what the sequencer offers while it is idle.
	typedef enum logic [2:0]
	{
		NOP  = 3'd0,
		PRCH = 3'd1,
		ACTV = 3'd2,
		READ = 3'd3,
		WRTE = 3'd4
	} sdram_cmd_t;

	// page (row) address, which also fills the address pins.
	typedef logic [`SDRAM_ROW_BITS-1:0] row_addr_t;

	// column inside the open page.
	typedef logic [`SDRAM_COL_BITS-1:0] col_addr_t;

	// control and address pins toward the SDRAM, all active low except addr.
	typedef struct packed
	{
		logic      cs_n;
		logic      ras_n;
		logic      cas_n;
		logic      we_n;
		row_addr_t addr;
	} sdram_pins_t;

endpackage
